// ==== logic/dm_pkg.sv ====
// shared debug module definitions; NUM_HARTS of at least 2, Access Register over GPRs only
package dm_pkg;

    localparam int NUM_HARTS      = 2;
    localparam int HARTSEL_BITS   = $clog2(NUM_HARTS);
    localparam int DATA_COUNT     = 2;
    localparam int DATA_IDX_BITS  = $clog2(DATA_COUNT);
    localparam int XLEN           = 64;
    localparam int NUM_PHYS_REGS  = 64;
    localparam int PHYS_REG_BITS  = $clog2(NUM_PHYS_REGS);
    localparam int LOGI_REG_BITS  = 5;
    localparam int DMI_ADDR_WIDTH = 7;
    localparam int DMI_DATA_WIDTH = 32;
    localparam int DMI_OP_WIDTH   = 2;

    // dm register map
    localparam logic [DMI_ADDR_WIDTH-1:0] ADDR_DATA0      = 7'h04;
    localparam logic [DMI_ADDR_WIDTH-1:0] ADDR_DMCONTROL  = 7'h10;
    localparam logic [DMI_ADDR_WIDTH-1:0] ADDR_DMSTATUS   = 7'h11;
    localparam logic [DMI_ADDR_WIDTH-1:0] ADDR_ABSTRACTCS = 7'h16;
    localparam logic [DMI_ADDR_WIDTH-1:0] ADDR_COMMAND    = 7'h17;

    localparam logic [15:0] GPR_REGNO_FIRST = 16'h1000;  // x0
    localparam logic [15:0] GPR_REGNO_LAST  = 16'h101f;  // x31
    localparam logic [3:0]  DM_VERSION      = 4'd3;      // spec 1.0

    typedef enum logic [DMI_OP_WIDTH-1:0] {
        DMI_OP_NOP   = 2'd0,
        DMI_OP_READ  = 2'd1,
        DMI_OP_WRITE = 2'd2
    } dmi_op_e;

    typedef enum logic [DMI_OP_WIDTH-1:0] {
        DMI_OK     = 2'd0,
        DMI_FAILED = 2'd2
    } dmi_status_e;

    typedef enum logic [2:0] {
        CMDERR_NONE          = 3'd0,
        CMDERR_NOT_SUPPORTED = 3'd2,
        CMDERR_HALT_RESUME   = 3'd4
    } cmderr_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RESPOND,
        ST_WAIT_CMD
    } dm_state_e;

    typedef struct packed {
        logic [DMI_ADDR_WIDTH-1:0] addr;
        logic [DMI_DATA_WIDTH-1:0] data;
        dmi_op_e                   op;
    } dmi_req_t;

    typedef struct packed {
        logic [DMI_DATA_WIDTH-1:0] data;
        dmi_status_e               status;
    } dmi_resp_t;

    typedef struct packed {
        logic       haltreq;
        logic       resumereq;
        logic       hartreset;
        logic       ackhavereset;
        logic       ackunavail;
        logic       hasel;
        logic [9:0] hartsello;
        logic [9:0] hartselhi;
        logic       setkeepalive;
        logic       clrkeepalive;
        logic       setresethaltreq;
        logic       clrresethaltreq;
        logic       ndmreset;
        logic       dmactive;
    } dmcontrol_t;

    typedef struct packed {
        logic [6:0] zero0;
        logic       ndmresetpending;
        logic       stickyunavail;
        logic       impebreak;
        logic [1:0] zero1;
        logic       allhavereset;
        logic       anyhavereset;
        logic       allresumeack;
        logic       anyresumeack;
        logic       allnonexistent;
        logic       anynonexistent;
        logic       allunavail;
        logic       anyunavail;
        logic       allrunning;
        logic       anyrunning;
        logic       allhalted;
        logic       anyhalted;
        logic       authenticated;
        logic       authbusy;
        logic       hasresethaltreq;
        logic       confstrptrvalid;
        logic [3:0] version;
    } dmstatus_t;

    typedef struct packed {
        logic [2:0]  zero3;
        logic [4:0]  progbufsize;
        logic [10:0] zero2;
        logic        busy;
        logic        relaxedpriv;
        cmderr_e     cmderr;
        logic [3:0]  zero1;
        logic [3:0]  datacount;
    } abstractcs_t;

    // access register layout, postincrement and postexec bits kept as zero
    typedef struct packed {
        logic [7:0]  cmdtype;
        logic        zero0;
        logic [2:0]  aarsize;
        logic [1:0]  zero1;
        logic        transfer;
        logic        write;
        logic [15:0] regno;
    } command_t;

    typedef struct packed {
        logic [NUM_HARTS-1:0] running;
        logic [NUM_HARTS-1:0] halted;
        logic [NUM_HARTS-1:0] resumeack;
    } hart_status_t;

    typedef struct packed {
        logic [NUM_HARTS-1:0]                    rnm_en;
        logic [NUM_HARTS-1:0][LOGI_REG_BITS-1:0] rnm_reg;
        logic [NUM_HARTS-1:0]                    rf_re;
        logic [NUM_HARTS-1:0]                    rf_we;
        logic [NUM_HARTS-1:0][PHYS_REG_BITS-1:0] rf_preg;
        logic [NUM_HARTS-1:0][XLEN-1:0]          rf_wdata;
    } rf_req_t;

    typedef struct packed {
        logic [NUM_HARTS-1:0][PHYS_REG_BITS-1:0] rnm_preg;
        logic [NUM_HARTS-1:0][XLEN-1:0]          rf_rdata;
    } rf_resp_t;

endpackage

// ==== logic/data_buf.sv ====
// abstract data words; a register read overrides a DMI write, which cannot coincide anyway
module data_buf (
    input  logic                                                    clk_i,
    input  logic                                                    rstn_i,
    input  logic                                                    dmi_we_i,
    input  logic [dm_pkg::DATA_IDX_BITS-1:0]                        dmi_idx_i,
    input  logic [dm_pkg::DMI_DATA_WIDTH-1:0]                       dmi_wdata_i,
    input  logic                                                    rd_we_i,
    input  logic                                                    rd_wide_i,
    input  logic [dm_pkg::XLEN-1:0]                                 rd_data_i,
    output logic [dm_pkg::DATA_COUNT-1:0][dm_pkg::DMI_DATA_WIDTH-1:0] data_o
);
    import dm_pkg::*;

    logic [DATA_COUNT-1:0][DMI_DATA_WIDTH-1:0] data_q;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            data_q <= '0;
        end else if (rd_we_i) begin
            data_q[0] <= rd_data_i[DMI_DATA_WIDTH-1:0];
            if (rd_wide_i) begin
                data_q[1] <= rd_data_i[XLEN-1:DMI_DATA_WIDTH];  // upper half to data1
            end
        end else if (dmi_we_i) begin
            data_q[dmi_idx_i] <= dmi_wdata_i;
        end
    end

    assign data_o = data_q;

endmodule

// ==== logic/abstract_cmd.sv ====
// access register only, no postexec; transfer needs a halted hart and GPR regno
module abstract_cmd (
    input  logic                                                    clk_i,
    input  logic                                                    rstn_i,
    input  logic                                                    cmd_start_i,
    input  logic                                                    wr_abstractcs_i,
    input  logic [dm_pkg::DMI_DATA_WIDTH-1:0]                       wdata_i,
    input  logic [dm_pkg::HARTSEL_BITS-1:0]                         hartsel_i,
    input  logic                                                    sel_halted_i,
    input  logic [dm_pkg::DATA_COUNT-1:0][dm_pkg::DMI_DATA_WIDTH-1:0] data_i,
    output logic                                                    cmd_done_o,
    output dm_pkg::abstractcs_t                                     abstractcs_o,
    output logic                                                    rd_we_o,
    output logic                                                    rd_wide_o,
    output logic [dm_pkg::XLEN-1:0]                                 rd_data_o,
    output dm_pkg::rf_req_t                                         rf_req_o,
    input  dm_pkg::rf_resp_t                                        rf_resp_i
);
    import dm_pkg::*;

    command_t                 cmd;
    abstractcs_t              wr_acs;
    logic                     gpr_ok;
    logic                     size_ok;
    cmderr_e                  cmderr_q;
    logic                     rnm_q;   // rename cycle
    logic                     rf_q;    // regfile cycle
    logic                     done_q;
    logic [LOGI_REG_BITS-1:0] lreg_q;
    logic                     write_q;
    logic                     wide_q;
    logic [PHYS_REG_BITS-1:0] preg_q;
    logic [XLEN-1:0]          wr_data;

    assign cmd     = command_t'(wdata_i);
    assign wr_acs  = abstractcs_t'(wdata_i);
    assign gpr_ok  = (cmd.regno >= GPR_REGNO_FIRST) && (cmd.regno <= GPR_REGNO_LAST);
    assign size_ok = (cmd.aarsize == 3'd2) || (cmd.aarsize == 3'd3);

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            cmderr_q <= CMDERR_NONE;
            rnm_q    <= 1'b0;
            rf_q     <= 1'b0;
            done_q   <= 1'b0;
        end else begin
            rnm_q  <= 1'b0;
            rf_q   <= rnm_q;
            done_q <= rf_q;  // answer after the write-back edge
            if (wr_abstractcs_i) begin
                cmderr_q <= cmderr_e'(cmderr_q & ~wr_acs.cmderr);  // write 1 to clear
            end else if (cmd_start_i) begin
                if (cmderr_q != CMDERR_NONE) begin
                    done_q <= 1'b1;
                end else if (!sel_halted_i) begin
                    cmderr_q <= CMDERR_HALT_RESUME;
                    done_q   <= 1'b1;
                end else if (cmd.cmdtype != 8'd0 || (cmd.transfer && !(gpr_ok && size_ok))) begin
                    cmderr_q <= CMDERR_NOT_SUPPORTED;
                    done_q   <= 1'b1;
                end else begin
                    rnm_q  <= cmd.transfer;
                    done_q <= !cmd.transfer;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (cmd_start_i) begin
            lreg_q  <= cmd.regno[LOGI_REG_BITS-1:0];
            write_q <= cmd.write;
            wide_q  <= (cmd.aarsize == 3'd3);
        end
        if (rnm_q) begin
            preg_q <= rf_resp_i.rnm_preg[hartsel_i];
        end
    end

    assign wr_data = wide_q ? {data_i[1], data_i[0]} : {{(XLEN-DMI_DATA_WIDTH){1'b0}}, data_i[0]};

    // only the selected hart sees enables, the rest stay zero
    always_comb begin
        rf_req_o = '0;
        for (int h = 0; h < NUM_HARTS; h++) begin
            if (h == int'(hartsel_i)) begin
                rf_req_o.rnm_en[h]   = rnm_q;
                rf_req_o.rnm_reg[h]  = lreg_q;
                rf_req_o.rf_re[h]    = rf_q && !write_q;
                rf_req_o.rf_we[h]    = rf_q && write_q;
                rf_req_o.rf_preg[h]  = preg_q;
                rf_req_o.rf_wdata[h] = wr_data;
            end
        end
    end

    assign rd_we_o    = rf_q && !write_q;
    assign rd_wide_o  = wide_q;
    assign rd_data_o  = rf_resp_i.rf_rdata[hartsel_i];
    assign cmd_done_o = done_q;

    always_comb begin
        abstractcs_o           = '0;
        abstractcs_o.datacount = 4'(DATA_COUNT);
        abstractcs_o.busy      = rnm_q || rf_q;
        abstractcs_o.cmderr    = cmderr_q;
    end

    // each regfile access follows a rename on the same hart, never read and write at once
    a_rf_after_rename: assert property (@(posedge clk_i) disable iff (!rstn_i)
        |(rf_req_o.rf_re | rf_req_o.rf_we) |->
            !(|(rf_req_o.rf_re & rf_req_o.rf_we)) &&
            ($past(rf_req_o.rnm_en) == (rf_req_o.rf_re | rf_req_o.rf_we)));

endmodule

// ==== logic/hart_ctrl.sv ====
// run control; dmstatus summarizes the selected hart only, no hart array window
module hart_ctrl (
    input  logic                              clk_i,
    input  logic                              rstn_i,
    input  logic                              wr_dmcontrol_i,
    input  logic [dm_pkg::DMI_DATA_WIDTH-1:0] wdata_i,
    input  dm_pkg::hart_status_t              status_i,
    output logic [dm_pkg::NUM_HARTS-1:0]      halt_req_o,
    output logic [dm_pkg::NUM_HARTS-1:0]      resume_req_o,
    output logic [dm_pkg::HARTSEL_BITS-1:0]   hartsel_o,
    output logic                              sel_halted_o,
    output dm_pkg::dmcontrol_t                dmcontrol_o,
    output dm_pkg::dmstatus_t                 dmstatus_o
);
    import dm_pkg::*;

    dmcontrol_t              wr_ctl;
    logic [19:0]             wr_hartsel;
    logic [HARTSEL_BITS-1:0] hartsel_q, hartsel_d;
    logic                    dmactive_q;
    logic [NUM_HARTS-1:0]    haltreq_q, haltreq_d;
    logic [NUM_HARTS-1:0]    resumereq_q, resumereq_d;
    logic [NUM_HARTS-1:0]    ack_q, ack_d;

    assign wr_ctl     = dmcontrol_t'(wdata_i);
    assign wr_hartsel = {wr_ctl.hartselhi, wr_ctl.hartsello};

    always_comb begin
        hartsel_d   = hartsel_q;
        haltreq_d   = haltreq_q;
        resumereq_d = resumereq_q & ~status_i.resumeack;  // drop once acked
        ack_d       = ack_q | status_i.resumeack;
        if (wr_dmcontrol_i) begin
            if (wr_hartsel < 20'(NUM_HARTS)) begin
                hartsel_d = wr_hartsel[HARTSEL_BITS-1:0];
            end
            haltreq_d[hartsel_d] = wr_ctl.haltreq;
            if (wr_ctl.haltreq) begin
                resumereq_d[hartsel_d] = 1'b0;  // halt wins over a pending resume
            end else if (!haltreq_q[hartsel_d]) begin
                resumereq_d[hartsel_d] = wr_ctl.resumereq;
                if (wr_ctl.resumereq) begin
                    ack_d[hartsel_d] = 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            hartsel_q   <= '0;
            dmactive_q  <= 1'b0;
            haltreq_q   <= '0;
            resumereq_q <= '0;
            ack_q       <= '0;
        end else begin
            hartsel_q   <= hartsel_d;
            haltreq_q   <= haltreq_d;
            resumereq_q <= resumereq_d;
            ack_q       <= ack_d;
            if (wr_dmcontrol_i) begin
                dmactive_q <= wr_ctl.dmactive;
            end
        end
    end

    assign halt_req_o   = haltreq_q;
    assign resume_req_o = resumereq_q;
    assign hartsel_o    = hartsel_q;
    assign sel_halted_o = status_i.halted[hartsel_q];

    always_comb begin
        dmcontrol_o           = '0;
        dmcontrol_o.haltreq   = haltreq_q[hartsel_q];
        dmcontrol_o.hartsello = 10'(hartsel_q);
        dmcontrol_o.dmactive  = dmactive_q;

        dmstatus_o               = '0;
        dmstatus_o.allresumeack  = ack_q[hartsel_q];
        dmstatus_o.anyresumeack  = ack_q[hartsel_q];
        dmstatus_o.allrunning    = status_i.running[hartsel_q];
        dmstatus_o.anyrunning    = status_i.running[hartsel_q];
        dmstatus_o.allhalted     = status_i.halted[hartsel_q];
        dmstatus_o.anyhalted     = status_i.halted[hartsel_q];
        dmstatus_o.authenticated = 1'b1;  // no auth scheme
        dmstatus_o.version       = DM_VERSION;
    end

    a_no_halt_and_resume: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(|(haltreq_q & resumereq_q)));

endmodule

// ==== logic/dmi_front.sv ====
// dmi front end; one transaction in flight, every response status is ok
module dmi_front (
    input  logic                                                    clk_i,
    input  logic                                                    rstn_i,
    input  logic                                                    req_valid_i,
    output logic                                                    req_ready_o,
    input  dm_pkg::dmi_req_t                                        req_i,
    output logic                                                    resp_valid_o,
    input  logic                                                    resp_ready_i,
    output dm_pkg::dmi_resp_t                                       resp_o,
    input  dm_pkg::dmstatus_t                                       dmstatus_i,
    input  dm_pkg::abstractcs_t                                     abstractcs_i,
    input  dm_pkg::dmcontrol_t                                      dmcontrol_i,
    input  logic [dm_pkg::DATA_COUNT-1:0][dm_pkg::DMI_DATA_WIDTH-1:0] data_i,
    input  logic                                                    cmd_done_i,
    output logic                                                    wr_dmcontrol_o,
    output logic                                                    wr_abstractcs_o,
    output logic                                                    cmd_start_o,
    output logic [dm_pkg::DMI_DATA_WIDTH-1:0]                       wdata_o,
    output logic                                                    data_we_o,
    output logic [dm_pkg::DATA_IDX_BITS-1:0]                        data_idx_o
);
    import dm_pkg::*;

    dm_state_e                 state_q, state_d;
    dmi_resp_t                 resp_q, resp_d;
    logic                      accept;
    logic                      is_write;
    logic                      is_data;
    logic [DMI_ADDR_WIDTH-1:0] data_off;

    assign req_ready_o = (state_q == ST_IDLE);
    assign accept      = req_valid_i && req_ready_o;
    assign is_write    = (req_i.op == DMI_OP_WRITE);
    assign data_off    = req_i.addr - ADDR_DATA0;  // wraps high below data0
    assign is_data     = data_off < DMI_ADDR_WIDTH'(DATA_COUNT);

    // write strobes fire in the accept cycle
    assign wr_dmcontrol_o  = accept && is_write && (req_i.addr == ADDR_DMCONTROL);
    assign wr_abstractcs_o = accept && is_write && (req_i.addr == ADDR_ABSTRACTCS);
    assign cmd_start_o     = accept && is_write && (req_i.addr == ADDR_COMMAND);
    assign data_we_o       = accept && is_write && is_data;
    assign data_idx_o      = data_off[DATA_IDX_BITS-1:0];
    assign wdata_o         = req_i.data;

    // read data, writes and nops answer zero
    always_comb begin
        resp_d.data   = '0;
        resp_d.status = DMI_OK;
        if (req_i.op == DMI_OP_READ) begin
            case (req_i.addr)
                ADDR_DMCONTROL:  resp_d.data = dmcontrol_i;
                ADDR_DMSTATUS:   resp_d.data = dmstatus_i;
                ADDR_ABSTRACTCS: resp_d.data = abstractcs_i;
                default: begin
                    if (is_data) begin
                        resp_d.data = data_i[data_idx_o];
                    end
                end
            endcase
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (accept) begin
                    state_d = cmd_start_o ? ST_WAIT_CMD : ST_RESPOND;
                end
            end
            ST_RESPOND: begin
                if (resp_ready_i) begin
                    state_d = ST_IDLE;
                end
            end
            ST_WAIT_CMD: begin
                if (cmd_done_i) begin
                    state_d = resp_ready_i ? ST_IDLE : ST_RESPOND;  // park if stalled
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    assign resp_valid_o = (state_q == ST_RESPOND) || ((state_q == ST_WAIT_CMD) && cmd_done_i);
    assign resp_o       = resp_q;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            resp_q <= resp_d;
        end
    end

    // covers the command path too, where valid comes from abstract_cmd
    a_resp_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable(resp_o));

endmodule

// ==== logic/dm_top.sv ====
// debug module top; hart side must answer rename and regfile reads in the same cycle
module dm_top (
    input  logic                          clk_i,
    input  logic                          rstn_i,
    input  logic                          req_valid_i,
    output logic                          req_ready_o,
    input  dm_pkg::dmi_req_t              req_i,
    output logic                          resp_valid_o,
    input  logic                          resp_ready_i,
    output dm_pkg::dmi_resp_t             resp_o,
    output logic [dm_pkg::NUM_HARTS-1:0]  halt_req_o,
    output logic [dm_pkg::NUM_HARTS-1:0]  resume_req_o,
    input  dm_pkg::hart_status_t          status_i,
    output dm_pkg::rf_req_t               rf_req_o,
    input  dm_pkg::rf_resp_t              rf_resp_i
);
    import dm_pkg::*;

    logic                                      wr_dmcontrol;
    logic                                      wr_abstractcs;
    logic                                      cmd_start;
    logic                                      cmd_done;
    logic [DMI_DATA_WIDTH-1:0]                 wdata;
    logic                                      data_we;
    logic [DATA_IDX_BITS-1:0]                  data_idx;
    logic [DATA_COUNT-1:0][DMI_DATA_WIDTH-1:0] data;
    logic [HARTSEL_BITS-1:0]                   hartsel;
    logic                                      sel_halted;
    logic                                      rd_we;
    logic                                      rd_wide;
    logic [XLEN-1:0]                           rd_data;
    dmcontrol_t                                dmcontrol;
    dmstatus_t                                 dmstatus;
    abstractcs_t                               abstractcs;

    dmi_front dmi_front_i (
        .clk_i, .rstn_i, .req_valid_i, .req_ready_o, .req_i,
        .resp_valid_o, .resp_ready_i, .resp_o,
        .dmstatus_i(dmstatus), .abstractcs_i(abstractcs), .dmcontrol_i(dmcontrol),
        .data_i(data), .cmd_done_i(cmd_done),
        .wr_dmcontrol_o(wr_dmcontrol), .wr_abstractcs_o(wr_abstractcs),
        .cmd_start_o(cmd_start), .wdata_o(wdata),
        .data_we_o(data_we), .data_idx_o(data_idx)
    );

    hart_ctrl hart_ctrl_i (
        .clk_i, .rstn_i, .wr_dmcontrol_i(wr_dmcontrol), .wdata_i(wdata), .status_i,
        .halt_req_o, .resume_req_o, .hartsel_o(hartsel), .sel_halted_o(sel_halted),
        .dmcontrol_o(dmcontrol), .dmstatus_o(dmstatus)
    );

    abstract_cmd abstract_cmd_i (
        .clk_i, .rstn_i, .cmd_start_i(cmd_start), .wr_abstractcs_i(wr_abstractcs),
        .wdata_i(wdata), .hartsel_i(hartsel), .sel_halted_i(sel_halted), .data_i(data),
        .cmd_done_o(cmd_done), .abstractcs_o(abstractcs),
        .rd_we_o(rd_we), .rd_wide_o(rd_wide), .rd_data_o(rd_data),
        .rf_req_o, .rf_resp_i
    );

    data_buf data_buf_i (
        .clk_i, .rstn_i, .dmi_we_i(data_we), .dmi_idx_i(data_idx), .dmi_wdata_i(wdata),
        .rd_we_i(rd_we), .rd_wide_i(rd_wide), .rd_data_i(rd_data), .data_o(data)
    );

endmodule

// ==== testbench/hart_model.sv ====
// behavioral harts for the testbench; halt two cycles after haltreq, rename maps r to r+32
module hart_model (
    input  logic                         clk_i,
    input  logic                         rstn_i,
    input  logic [dm_pkg::NUM_HARTS-1:0] halt_req_i,
    input  logic [dm_pkg::NUM_HARTS-1:0] resume_req_i,
    output dm_pkg::hart_status_t         status_o,
    input  dm_pkg::rf_req_t              rf_req_i,
    output dm_pkg::rf_resp_t             rf_resp_o
);
    import dm_pkg::*;

    logic [NUM_HARTS-1:0] halted_q;
    logic [NUM_HARTS-1:0] ack_q;
    logic [NUM_HARTS-1:0] wait_q;  // first cycle of a halt request seen
    logic [XLEN-1:0]      regs_q [NUM_HARTS][NUM_PHYS_REGS];

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            halted_q <= '0;
            ack_q    <= '0;
            wait_q   <= '0;
            for (int h = 0; h < NUM_HARTS; h++) begin
                for (int p = 0; p < NUM_PHYS_REGS; p++) begin
                    regs_q[h][p] <= {8{8'(p)}};  // index in every byte
                end
            end
        end else begin
            ack_q <= '0;
            for (int h = 0; h < NUM_HARTS; h++) begin
                if (halted_q[h]) begin
                    wait_q[h] <= 1'b0;
                    if (resume_req_i[h]) begin
                        halted_q[h] <= 1'b0;
                        ack_q[h]    <= 1'b1;  // single cycle ack
                    end
                end else if (halt_req_i[h]) begin
                    wait_q[h] <= !wait_q[h];
                    if (wait_q[h]) begin
                        halted_q[h] <= 1'b1;
                    end
                end else begin
                    wait_q[h] <= 1'b0;
                end
                if (rf_req_i.rf_we[h]) begin
                    regs_q[h][rf_req_i.rf_preg[h]] <= rf_req_i.rf_wdata[h];
                end
            end
        end
    end

    // rename and regfile answer in the same cycle
    always_comb begin
        for (int h = 0; h < NUM_HARTS; h++) begin
            rf_resp_o.rnm_preg[h] = PHYS_REG_BITS'(rf_req_i.rnm_reg[h]) + PHYS_REG_BITS'(32);
            rf_resp_o.rf_rdata[h] = regs_q[h][rf_req_i.rf_preg[h]];
        end
    end

    assign status_o.running   = ~halted_q;
    assign status_o.halted    = halted_q;
    assign status_o.resumeack = ack_q;

endmodule

// ==== testbench/dm_tb.sv ====
// debug module testbench; run from the project root, stops at the first failing check
module dm_tb;
    import dm_pkg::*;

    localparam int RESET_CYCLES    = 8;
    localparam int CYCLES_PER_LINE = 40;

    logic         clk;
    logic         rstn;
    logic         req_valid;
    logic         req_ready;
    dmi_req_t     req;
    logic         resp_valid;
    logic         resp_ready;
    dmi_resp_t    resp;
    logic [NUM_HARTS-1:0] halt_req;
    logic [NUM_HARTS-1:0] resume_req;
    hart_status_t status;
    rf_req_t      rf_req;
    rf_resp_t     rf_resp;

    // parsed testdata
    string       name_list[$];
    int          kind_list[$];   // 0 response, 1 dmstatus, 2 abstractcs
    dmi_req_t    req_list[$];
    logic [31:0] exp_list[$];
    int          idle_list[$];

    int          err_cnt     = 0;
    int          cycle_cnt   = 0;
    int          cycle_limit = 0;
    logic [31:0] rng_state   = 32'd98829;

    dm_top dut_i (
        .clk_i(clk), .rstn_i(rstn),
        .req_valid_i(req_valid), .req_ready_o(req_ready), .req_i(req),
        .resp_valid_o(resp_valid), .resp_ready_i(resp_ready), .resp_o(resp),
        .halt_req_o(halt_req), .resume_req_o(resume_req), .status_i(status),
        .rf_req_o(rf_req), .rf_resp_i(rf_resp)
    );

    hart_model hart_model_i (
        .clk_i(clk), .rstn_i(rstn), .halt_req_i(halt_req), .resume_req_i(resume_req),
        .status_o(status), .rf_req_i(rf_req), .rf_resp_o(rf_resp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic report_failure(input string what);
        err_cnt++;
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check_resp(input string name, input dmi_resp_t exp, input dmi_resp_t act);
        if (act !== exp) begin
            report_failure($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_dmstatus(input string name, input dmstatus_t exp, input dmstatus_t act);
        if (act !== exp) begin
            report_failure($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_abstractcs(input string name, input abstractcs_t exp,
                                    input abstractcs_t act);
        if (act !== exp) begin
            report_failure($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic read_testdata();
        int          fd;
        int          n;
        int          kind;
        int          op;
        int          idle;
        string       line;
        string       name;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] exp;
        dmi_req_t    r;
        fd = $fopen("testbench/dm_testdata.txt", "r");
        if (fd == 0) begin
            report_failure("could not open testbench/dm_testdata.txt");
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;  // blank or comment
            end
            n = $sscanf(line, "%s %d %d %h %h %h %d", name, kind, op, addr, wdata, exp, idle);
            if (n != 7) begin
                report_failure($sformatf("testdata line could not be parsed: %s", line));
            end
            r.addr = addr[DMI_ADDR_WIDTH-1:0];
            r.data = wdata;
            r.op   = dmi_op_e'(op[DMI_OP_WIDTH-1:0]);
            name_list.push_back(name);
            kind_list.push_back(kind);
            req_list.push_back(r);
            exp_list.push_back(exp);
            idle_list.push_back(idle);
        end
        $fclose(fd);
    endtask

    task automatic run_txn(input int idx);
        int        hold;
        dmi_resp_t got;
        dmi_resp_t exp_resp;
        rng_state = xorshift(rng_state);
        hold      = rng_state[1] ? int'(rng_state[4:2]) : 0;  // back-pressure now and then
        @(posedge clk);
        req_valid  <= 1'b1;
        req        <= req_list[idx];
        resp_ready <= 1'b0;
        @(negedge clk);
        while (!req_ready) begin
            @(negedge clk);
        end
        @(posedge clk);  // accept edge
        req_valid <= 1'b0;
        repeat (hold) @(posedge clk);
        resp_ready <= 1'b1;
        @(negedge clk);
        while (!resp_valid) begin
            @(negedge clk);
        end
        got = resp;
        @(posedge clk);  // response transfer
        resp_ready <= 1'b0;
        exp_resp.data   = exp_list[idx];
        exp_resp.status = DMI_OK;
        case (kind_list[idx])
            1: check_dmstatus(name_list[idx], dmstatus_t'(exp_list[idx]), dmstatus_t'(got.data));
            2: check_abstractcs(name_list[idx], abstractcs_t'(exp_list[idx]),
                                abstractcs_t'(got.data));
            default: ;
        endcase
        check_resp(name_list[idx], exp_resp, got);
        repeat (idle_list[idx]) @(posedge clk);
    endtask

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            report_failure($sformatf("timeout: run did not end within %0d cycles", cycle_limit));
        end
    end

    initial begin
        rstn       = 1'b0;
        req_valid  = 1'b0;
        req        = '0;
        resp_ready = 1'b0;
        read_testdata();
        if (name_list.size() == 0) begin
            report_failure("testdata file holds no transactions");
        end
        cycle_limit = CYCLES_PER_LINE * name_list.size() + RESET_CYCLES;
        repeat (RESET_CYCLES) @(posedge clk);
        rstn <= 1'b1;
        for (int i = 0; i < name_list.size(); i++) begin
            run_txn(i);
        end
        if (err_cnt == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== testbench/dm_testdata.txt ====
# name kind op addr wdata expected idle; kind 0 response, 1 dmstatus, 2 abstractcs
# op 0 nop, 1 read, 2 write; addr, wdata and expected in hex, idle cycles in decimal
wr_data0        0 2 04 12345678 00000000 0
wr_data1        0 2 05 9abcdef0 00000000 0
rd_data0        0 1 04 00000000 12345678 0
rd_data1        0 1 05 00000000 9abcdef0 1
rd_unknown      0 1 3f 00000000 00000000 0
nop             0 0 04 00000000 00000000 0
dm_activate     0 2 10 00000001 00000000 0
st_hart0_run    1 1 11 00000000 00000c83 0
halt_hart1      0 2 10 80010001 00000000 4
st_hart1_halt   1 1 11 00000000 00000383 0
rd_dmcontrol    0 1 10 00000000 80010001 0
sel_hart0       0 2 10 00000001 00000000 0
st_hart0_sel    1 1 11 00000000 00000c83 0
sel_bad         0 2 10 00030001 00000000 0
rd_sel_kept     0 1 10 00000000 00000001 0
sel_hart1       0 2 10 80010001 00000000 0
wr64_x5         0 2 17 00331005 00000000 0
set_data0       0 2 04 00000000 00000000 0
set_data1       0 2 05 55555555 00000000 0
rd32_x5         0 2 17 00221005 00000000 0
rd32_data0      0 1 04 00000000 12345678 0
rd32_data1      0 1 05 00000000 55555555 0
rd64_x7         0 2 17 00321007 00000000 0
rd64_data0      0 1 04 00000000 27272727 0
rd64_data1      0 1 05 00000000 27272727 0
set_lo          0 2 04 cafef00d 00000000 0
wr32_x6         0 2 17 00231006 00000000 0
rd64_x6         0 2 17 00321006 00000000 0
rd_x6_lo        0 1 04 00000000 cafef00d 0
rd_x6_hi        0 1 05 00000000 00000000 0
acs_clean       2 1 16 00000000 00000002 0
halt_and_resume 0 2 10 c0010001 00000000 4
st_no_resume    1 1 11 00000000 00000383 0
clr_haltreq     0 2 10 00010001 00000000 0
resume_hart1    0 2 10 40010001 00000000 4
st_resumed      1 1 11 00000000 00030c83 0
cmd_running     0 2 17 00221005 00000000 0
acs_halt_resume 2 1 16 00000000 00000402 0
halt_hart0      0 2 10 80000001 00000000 4
cmd_ignored     0 2 17 00221005 00000000 0
rd_ignored      0 1 04 00000000 cafef00d 0
acs_still_set   2 1 16 00000000 00000402 0
clr_cmderr      0 2 16 00000700 00000000 0
acs_cleared     2 1 16 00000000 00000002 0
cmd_hart0       0 2 17 00221005 00000000 0
rd_hart0_x5     0 1 04 00000000 25252525 0
bad_regno       0 2 17 00221020 00000000 0
acs_bad_regno   2 1 16 00000000 00000202 0
clr_cmderr2     0 2 16 00000700 00000000 0
bad_size        0 2 17 00421005 00000000 0
acs_bad_size    2 1 16 00000000 00000202 0

// ==== src.f ====
logic/dm_pkg.sv
logic/data_buf.sv
logic/abstract_cmd.sv
logic/hart_ctrl.sv
logic/dmi_front.sv
logic/dm_top.sv
testbench/hart_model.sv
testbench/dm_tb.sv

// ==== Bender.yml ====
package:
  name: riscv_dm_lite

sources:
  - logic/dm_pkg.sv
  - logic/data_buf.sv
  - logic/abstract_cmd.sv
  - logic/hart_ctrl.sv
  - logic/dmi_front.sv
  - logic/dm_top.sv
  - target: test
    files:
      - testbench/hart_model.sv
      - testbench/dm_tb.sv
